/* source/saturn_pkg.sv */
// ******************************
// saturn_pkg
// shared widths, register selectors, ALU opcodes and
// instruction types for the nibble-serial core
// ******************************

package saturn_pkg;

    // datapath is one nibble wide, addresses count nibbles
    localparam int NIBBLE_W = 4;
    localparam int ADDR_W   = 20;

    // architectural register sizes in bits
    localparam int REG_ST_W = 16;
    localparam int REG_C_W  = 64;

    // operand nibbles that follow the jump opcodes
    localparam int JUMP_REL_NIBBLES = 3;
    localparam int JUMP_ABS_NIBBLES = 5;

    // register selectors for the ALU operand fields
    typedef enum logic [2:0] {
        REG_NONE = 3'd0,
        REG_P    = 3'd1,
        REG_ST   = 3'd2,
        REG_C    = 3'd3,
        REG_IMM  = 3'd4
    } alu_reg_t;

    // only copy is implemented in this core
    typedef enum logic [0:0] {
        OP_NOP  = 1'b0,
        OP_COPY = 1'b1
    } alu_op_t;

    // what the execute pulse applies to
    typedef enum logic [1:0] {
        INSTR_NONE     = 2'd0,
        INSTR_ALU      = 2'd1,
        INSTR_JUMP_REL = 2'd2,
        INSTR_JUMP_ABS = 2'd3
    } instr_type_t;

endpackage

/* source/saturn_phase_gen.sv */
// ******************************
// saturn_phase_gen
// four-phase nibble sequencer, one-hot output
// holds the access phase while the bus waits and parks on halt
// ******************************

`timescale 1ns/1ps

module saturn_phase_gen (
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_bus_busy,
    input  logic       i_halt,
    output logic [3:0] o_phases
);

    logic [1:0] phase_q;
    logic       running;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            phase_q <= 2'd0;
            running <= 1'b0;
        end else begin
            // error is sticky, so halt never releases
            running <= !i_halt;
            if (i_halt) begin
                phase_q <= 2'd0;
            end else if (running && !i_bus_busy) begin
                phase_q <= phase_q + 2'd1;
            end
        end
    end

    // no phase is active before the first step or once parked
    assign o_phases = running ? (4'b0001 << phase_q) : 4'b0000;

endmodule

/* source/saturn_fetch.sv */
// ******************************
// saturn_fetch
// program counter and APB read requester, one read per nibble
// loads relative or absolute jump targets on execute
// ******************************

`timescale 1ns/1ps

module saturn_fetch #(
    parameter logic [saturn_pkg::ADDR_W-1:0] RESET_PC = '0
) (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  logic [3:0]                      i_phases,
    input  logic [saturn_pkg::NIBBLE_W-1:0] i_prdata,
    input  logic                            i_pready,
    input  logic                            i_instr_execute,
    input  saturn_pkg::instr_type_t         i_instr_type,
    input  logic [saturn_pkg::ADDR_W-1:0]   i_instr_pc,
    input  logic [saturn_pkg::ADDR_W-1:0]   i_jump_field,
    output logic [saturn_pkg::ADDR_W-1:0]   o_paddr,
    output logic                            o_psel,
    output logic                            o_penable,
    output logic                            o_bus_busy,
    output logic [saturn_pkg::NIBBLE_W-1:0] o_nibble,
    output logic [saturn_pkg::ADDR_W-1:0]   o_current_pc
);

    import saturn_pkg::*;

    localparam int REL_W = JUMP_REL_NIBBLES * NIBBLE_W;

    logic [ADDR_W-1:0] pc;
    logic [ADDR_W-1:0] rel_target;
    logic [ADDR_W-1:0] jump_target;

    // offset counts from the first offset nibble, just past the opcode
    assign rel_target = i_instr_pc + 20'd1
                      + {{(ADDR_W-REL_W){i_jump_field[REL_W-1]}}, i_jump_field[REL_W-1:0]};

    assign jump_target = (i_instr_type == INSTR_JUMP_ABS) ? i_jump_field : rel_target;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pc <= RESET_PC;
        end else if (i_instr_execute &&
                     (i_instr_type == INSTR_JUMP_REL || i_instr_type == INSTR_JUMP_ABS)) begin
            pc <= jump_target;
        end else if (i_phases[2]) begin
            pc <= pc + 20'd1;
        end
    end

    // returned nibble, taken as the transfer completes
    always_ff @(posedge i_clk) begin
        if (i_phases[1] && i_pready) begin
            o_nibble <= i_prdata;
        end
    end

    // setup in phase 0, access in phase 1, pc is stable across both
    assign o_paddr      = pc;
    assign o_psel       = i_phases[0] | i_phases[1];
    assign o_penable    = i_phases[1];
    assign o_bus_busy   = i_phases[1] & ~i_pready;
    assign o_current_pc = pc;

endmodule

/* source/saturn_inst_decoder.sv */
// ******************************
// saturn_inst_decoder
// assembles instructions from the nibble stream, sets the ALU
// controls and jump field, pulses execute on the last nibble
// unknown opcodes raise a sticky error
// ******************************

`timescale 1ns/1ps

module saturn_inst_decoder (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  logic [3:0]                      i_phases,
    input  logic [saturn_pkg::NIBBLE_W-1:0] i_nibble,
    input  logic [saturn_pkg::ADDR_W-1:0]   i_current_pc,
    output logic [saturn_pkg::ADDR_W-1:0]   o_instr_pc,
    output saturn_pkg::alu_reg_t            o_alu_reg_dest,
    output saturn_pkg::alu_reg_t            o_alu_reg_src,
    output logic [3:0]                      o_alu_ptr,
    output logic [saturn_pkg::NIBBLE_W-1:0] o_alu_imm,
    output saturn_pkg::alu_op_t             o_alu_opcode,
    output saturn_pkg::instr_type_t         o_instr_type,
    output logic [saturn_pkg::ADDR_W-1:0]   o_jump_field,
    output logic                            o_instr_execute,
    output logic                            o_decoder_error
);

    import saturn_pkg::*;

    logic       decode_started;
    logic       block_2x;
    logic       block_8x;
    logic       block_80x;
    logic       block_80cx;
    logic       block_84x_85x;
    // shared by 6xxx and 8Dxxxxx, length tells them apart
    logic       block_jump;
    logic [2:0] jump_count;
    logic [2:0] jump_len;
    logic       jump_last;

    assign jump_last = (jump_count == jump_len - 3'd1);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            decode_started  <= 1'b0;
            block_2x        <= 1'b0;
            block_8x        <= 1'b0;
            block_80x       <= 1'b0;
            block_80cx      <= 1'b0;
            block_84x_85x   <= 1'b0;
            block_jump      <= 1'b0;
            jump_count      <= 3'd0;
            o_alu_reg_dest  <= REG_NONE;
            o_alu_reg_src   <= REG_NONE;
            o_alu_opcode    <= OP_NOP;
            o_instr_type    <= INSTR_NONE;
            o_instr_execute <= 1'b0;
            o_decoder_error <= 1'b0;
        end else begin
            // one clock wide, lands on phase 3
            o_instr_execute <= 1'b0;

            // start address of the next instruction
            if (i_phases[1] && !decode_started) begin
                o_instr_pc <= i_current_pc;
            end

            if (i_phases[2]) begin
                if (!decode_started) begin
                    case (i_nibble)
                        4'h2: begin
                            block_2x       <= 1'b1;
                            decode_started <= 1'b1;
                        end
                        4'h6: begin
                            block_jump     <= 1'b1;
                            jump_len       <= 3'(JUMP_REL_NIBBLES);
                            jump_count     <= 3'd0;
                            o_jump_field   <= '0;
                            o_instr_type   <= INSTR_JUMP_REL;
                            decode_started <= 1'b1;
                        end
                        4'h8: begin
                            block_8x       <= 1'b1;
                            decode_started <= 1'b1;
                        end
                        default: o_decoder_error <= 1'b1;
                    endcase
                end else if (block_2x) begin
                    // P=n
                    o_alu_reg_dest  <= REG_P;
                    o_alu_reg_src   <= REG_IMM;
                    o_alu_imm       <= i_nibble;
                    o_alu_opcode    <= OP_COPY;
                    o_instr_type    <= INSTR_ALU;
                    o_instr_execute <= 1'b1;
                    block_2x        <= 1'b0;
                    decode_started  <= 1'b0;
                end else if (block_jump) begin
                    // operand nibbles come in lsb first
                    o_jump_field[{jump_count, 2'b00} +: NIBBLE_W] <= i_nibble;
                    jump_count <= jump_count + 3'd1;
                    if (jump_last) begin
                        o_instr_execute <= 1'b1;
                        block_jump      <= 1'b0;
                        decode_started  <= 1'b0;
                    end
                end else if (block_8x) begin
                    block_8x <= 1'b0;
                    case (i_nibble)
                        4'h0: block_80x <= 1'b1;
                        4'h4, 4'h5: begin
                            // ST=0 n or ST=1 n, value is the low opcode bit
                            o_alu_reg_dest <= REG_ST;
                            o_alu_reg_src  <= REG_IMM;
                            o_alu_imm      <= {3'b000, i_nibble[0]};
                            o_alu_opcode   <= OP_COPY;
                            o_instr_type   <= INSTR_ALU;
                            block_84x_85x  <= 1'b1;
                        end
                        4'hD: begin
                            block_jump   <= 1'b1;
                            jump_len     <= 3'(JUMP_ABS_NIBBLES);
                            jump_count   <= 3'd0;
                            o_jump_field <= '0;
                            o_instr_type <= INSTR_JUMP_ABS;
                        end
                        default: begin
                            o_decoder_error <= 1'b1;
                            decode_started  <= 1'b0;
                        end
                    endcase
                end else if (block_80x) begin
                    block_80x <= 1'b0;
                    if (i_nibble == 4'hC) begin
                        block_80cx <= 1'b1;
                    end else begin
                        o_decoder_error <= 1'b1;
                        decode_started  <= 1'b0;
                    end
                end else if (block_80cx) begin
                    // C=P n, the nibble picks the target field of C
                    o_alu_reg_dest  <= REG_C;
                    o_alu_reg_src   <= REG_P;
                    o_alu_ptr       <= i_nibble;
                    o_alu_opcode    <= OP_COPY;
                    o_instr_type    <= INSTR_ALU;
                    o_instr_execute <= 1'b1;
                    block_80cx      <= 1'b0;
                    decode_started  <= 1'b0;
                end else if (block_84x_85x) begin
                    // status bit number, controls already set
                    o_alu_ptr       <= i_nibble;
                    o_instr_execute <= 1'b1;
                    block_84x_85x   <= 1'b0;
                    decode_started  <= 1'b0;
                end
            end
        end
    end

endmodule

/* source/saturn_regs.sv */
// ******************************
// saturn_regs
// P, ST and C registers, executes decoded copy operations
// ******************************

`timescale 1ns/1ps

module saturn_regs (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  logic                            i_execute,
    input  saturn_pkg::instr_type_t         i_instr_type,
    input  saturn_pkg::alu_reg_t            i_alu_reg_dest,
    input  saturn_pkg::alu_reg_t            i_alu_reg_src,
    input  logic [3:0]                      i_alu_ptr,
    input  logic [saturn_pkg::NIBBLE_W-1:0] i_alu_imm,
    input  saturn_pkg::alu_op_t             i_alu_opcode,
    output logic [saturn_pkg::NIBBLE_W-1:0] o_reg_p,
    output logic [saturn_pkg::REG_ST_W-1:0] o_reg_st,
    output logic [saturn_pkg::REG_C_W-1:0]  o_reg_c
);

    import saturn_pkg::*;

    logic [NIBBLE_W-1:0] src_value;
    logic                do_copy;

    // source operand, only P and the immediate feed copies here
    always_comb begin
        case (i_alu_reg_src)
            REG_IMM: src_value = i_alu_imm;
            REG_P:   src_value = o_reg_p;
            default: src_value = '0;
        endcase
    end

    assign do_copy = i_execute && (i_instr_type == INSTR_ALU) && (i_alu_opcode == OP_COPY);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_reg_p  <= '0;
            o_reg_st <= '0;
            o_reg_c  <= '0;
        end else if (do_copy) begin
            case (i_alu_reg_dest)
                REG_P: begin
                    o_reg_p <= src_value;
                end
                REG_ST: begin
                    o_reg_st[i_alu_ptr] <= src_value[0];
                end
                REG_C: begin
                    // pointer selects one nibble of the 16 in C
                    o_reg_c[{i_alu_ptr, 2'b00} +: NIBBLE_W] <= src_value;
                end
                default: begin
                    o_reg_p <= o_reg_p;
                end
            endcase
        end
    end

endmodule

/* source/saturn_core.sv */
// ******************************
// saturn_core
// nibble-serial front end: sequencer, fetch over APB,
// decoder and register unit
// ******************************

`timescale 1ns/1ps

module saturn_core #(
    parameter logic [saturn_pkg::ADDR_W-1:0] RESET_PC = '0
) (
    input  logic                            i_clk,
    input  logic                            i_reset,
    // APB requester, read only
    output logic [saturn_pkg::ADDR_W-1:0]   o_paddr,
    output logic                            o_psel,
    output logic                            o_penable,
    input  logic [saturn_pkg::NIBBLE_W-1:0] i_prdata,
    input  logic                            i_pready,
    // observation
    output logic                            o_instr_done,
    output logic [saturn_pkg::ADDR_W-1:0]   o_instr_pc,
    output logic [saturn_pkg::NIBBLE_W-1:0] o_reg_p,
    output logic [saturn_pkg::REG_ST_W-1:0] o_reg_st,
    output logic [saturn_pkg::REG_C_W-1:0]  o_reg_c,
    output logic                            o_error
);

    import saturn_pkg::*;

    logic [3:0]          phases;
    logic                bus_busy;
    logic [NIBBLE_W-1:0] nibble;
    logic [ADDR_W-1:0]   current_pc;
    logic [ADDR_W-1:0]   instr_pc;
    alu_reg_t            alu_reg_dest;
    alu_reg_t            alu_reg_src;
    logic [3:0]          alu_ptr;
    logic [NIBBLE_W-1:0] alu_imm;
    alu_op_t             alu_opcode;
    instr_type_t         instr_type;
    logic [ADDR_W-1:0]   jump_field;
    logic                instr_execute;
    logic                decoder_error;

    saturn_phase_gen u_phase_gen (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_bus_busy (bus_busy),
        .i_halt     (decoder_error),
        .o_phases   (phases)
    );

    saturn_fetch #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_phases        (phases),
        .i_prdata        (i_prdata),
        .i_pready        (i_pready),
        .i_instr_execute (instr_execute),
        .i_instr_type    (instr_type),
        .i_instr_pc      (instr_pc),
        .i_jump_field    (jump_field),
        .o_paddr         (o_paddr),
        .o_psel          (o_psel),
        .o_penable       (o_penable),
        .o_bus_busy      (bus_busy),
        .o_nibble        (nibble),
        .o_current_pc    (current_pc)
    );

    saturn_inst_decoder u_decoder (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_phases        (phases),
        .i_nibble        (nibble),
        .i_current_pc    (current_pc),
        .o_instr_pc      (instr_pc),
        .o_alu_reg_dest  (alu_reg_dest),
        .o_alu_reg_src   (alu_reg_src),
        .o_alu_ptr       (alu_ptr),
        .o_alu_imm       (alu_imm),
        .o_alu_opcode    (alu_opcode),
        .o_instr_type    (instr_type),
        .o_jump_field    (jump_field),
        .o_instr_execute (instr_execute),
        .o_decoder_error (decoder_error)
    );

    saturn_regs u_regs (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_execute      (instr_execute),
        .i_instr_type   (instr_type),
        .i_alu_reg_dest (alu_reg_dest),
        .i_alu_reg_src  (alu_reg_src),
        .i_alu_ptr      (alu_ptr),
        .i_alu_imm      (alu_imm),
        .i_alu_opcode   (alu_opcode),
        .o_reg_p        (o_reg_p),
        .o_reg_st       (o_reg_st),
        .o_reg_c        (o_reg_c)
    );

    // execute pulse doubles as the completion strobe
    assign o_instr_done = instr_execute;
    assign o_instr_pc   = instr_pc;
    assign o_error      = decoder_error;

endmodule

/* bench/saturn_clock_gen.sv */
// ******************************
// saturn_clock_gen
// testbench clock, 40 ns period, and an 8-cycle reset
// ******************************

`timescale 1ns/1ps

module saturn_clock_gen (
    output logic o_clk,
    output logic o_reset
);

    initial begin
        o_clk = 1'b0;
        forever #20 o_clk = ~o_clk;
    end

    initial begin
        o_reset = 1'b1;
        repeat (8) @(posedge o_clk);
        #1 o_reset = 1'b0;
    end

endmodule

/* bench/saturn_core_tb.sv */
// ******************************
// saturn_core_tb
// random nibble program, APB memory with wait states,
// instruction-set model and register and bus checks
// ******************************

`timescale 1ns/1ps

module saturn_core_tb;

    localparam logic [19:0] RESET_PC = 20'h00010;
    localparam int N_INSTR = 200;
    // twice instructions x nibbles x clocks x period
    localparam longint WATCHDOG_NS = 64'd2 * N_INSTR * 7 * 7 * 40;

    logic        clk;
    logic        rst;
    logic [19:0] paddr;
    logic        psel;
    logic        penable;
    logic [3:0]  prdata;
    logic        pready;
    logic        instr_done;
    logic [19:0] instr_pc;
    logic [3:0]  reg_p;
    logic [15:0] reg_st;
    logic [63:0] reg_c;
    logic        error;

    logic [3:0]  mem [0:4095];
    integer      seed = 31388;
    int          errors = 0;
    int          done_count = 0;
    int          waits = 0;
    int          term_addr;

    // instruction-set model state
    logic [3:0]  m_p = '0;
    logic [15:0] m_st = '0;
    logic [63:0] m_c = '0;
    logic [19:0] m_pc = RESET_PC;
    logic [19:0] exp_addr = RESET_PC;
    logic [19:0] setup_addr = '0;
    logic        regs_pending = 1'b0;
    logic        prev_setup = 1'b0;
    logic        prev_wait = 1'b0;

    saturn_clock_gen u_clock_gen (
        .o_clk   (clk),
        .o_reset (rst)
    );

    saturn_core #(
        .RESET_PC (RESET_PC)
    ) u_dut (
        .i_clk        (clk),
        .i_reset      (rst),
        .o_paddr      (paddr),
        .o_psel       (psel),
        .o_penable    (penable),
        .i_prdata     (prdata),
        .i_pready     (pready),
        .o_instr_done (instr_done),
        .o_instr_pc   (instr_pc),
        .o_reg_p      (reg_p),
        .o_reg_st     (reg_st),
        .o_reg_c      (reg_c),
        .o_error      (error)
    );

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        assert (got === exp) else begin
            $display("error: %s is %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        assert (cond) else begin
            $display("failure: %s", what);
            errors++;
        end
    endtask

    // GOTO at addr with the offset counted from the first offset nibble
    task automatic put_goto(input int at, input int target);
        logic [11:0] off;
        off = 12'(target - (at + 1));
        mem[at]     = 4'h6;
        mem[at + 1] = off[3:0];
        mem[at + 2] = off[7:4];
        mem[at + 3] = off[11:8];
    endtask

    task automatic build_program();
        int a;
        int count;
        int k;
        int kind;
        logic [19:0] t;
        a = RESET_PC;
        count = 0;
        for (int i = 0; i < 4096; i++) begin
            mem[i] = 4'h0;
        end
        while (count < N_INSTR) begin
            kind = rand_below((count <= N_INSTR - 4) ? 7 : 6);
            k = rand_below(8);
            case (kind)
                0: begin
                    mem[a] = 4'h2;
                    mem[a + 1] = 4'(rand_below(16));
                    a += 2;
                end
                1: begin
                    mem[a] = 4'h8;
                    mem[a + 1] = 4'h0;
                    mem[a + 2] = 4'hC;
                    mem[a + 3] = 4'(rand_below(16));
                    a += 4;
                end
                2, 3: begin
                    mem[a] = 4'h8;
                    mem[a + 1] = (kind == 2) ? 4'h4 : 4'h5;
                    mem[a + 2] = 4'(rand_below(16));
                    a += 3;
                end
                4: begin
                    put_goto(a, a + 4 + k);
                    a += 4 + k;
                end
                5: begin
                    t = 20'(a + 7 + k);
                    mem[a] = 4'h8;
                    mem[a + 1] = 4'hD;
                    for (int j = 0; j < 5; j++) begin
                        mem[a + 2 + j] = t[4*j +: 4];
                    end
                    a += 7 + k;
                end
                default: begin
                    // forward over a hole, back into it, then out again
                    put_goto(a, a + 16);
                    put_goto(a + 16, a + 4);
                    mem[a + 4] = 4'h2;
                    mem[a + 5] = 4'(rand_below(16));
                    put_goto(a + 6, a + 20);
                    a += 20;
                    count += 3;
                end
            endcase
            count++;
        end
        mem[a] = 4'h0;
        term_addr = a;
    endtask

    // steps one instruction and moves m_pc on to the next one
    task automatic model_step();
        logic [3:0]  n0;
        logic [3:0]  n1;
        logic [11:0] off;
        logic [19:0] t;
        n0 = mem[m_pc[11:0]];
        n1 = mem[m_pc[11:0] + 1];
        if (n0 == 4'h2) begin
            m_p = n1;
            m_pc = m_pc + 2;
        end else if (n0 == 4'h6) begin
            off = {mem[m_pc[11:0] + 3], mem[m_pc[11:0] + 2], n1};
            m_pc = m_pc + 1 + {{8{off[11]}}, off};
        end else if (n0 == 4'h8 && n1 == 4'h0) begin
            m_c[{mem[m_pc[11:0] + 3], 2'b00} +: 4] = m_p;
            m_pc = m_pc + 4;
        end else if (n0 == 4'h8 && (n1 == 4'h4 || n1 == 4'h5)) begin
            m_st[mem[m_pc[11:0] + 2]] = n1[0];
            m_pc = m_pc + 3;
        end else if (n0 == 4'h8 && n1 == 4'hD) begin
            for (int j = 0; j < 5; j++) begin
                t[4*j +: 4] = mem[m_pc[11:0] + 2 + j];
            end
            m_pc = t;
        end else begin
            expect_true(1'b0, "done pulse for an opcode the model does not know");
        end
    endtask

    // memory model answers each read after 0 to 3 wait states
    always @(posedge clk) begin
        #1;
        pready = 1'b0;
        if (psel && !penable) begin
            waits = rand_below(4);
        end else if (psel && penable) begin
            if (waits == 0) begin
                pready = 1'b1;
                prdata = mem[paddr[11:0]];
            end else begin
                waits--;
            end
        end
    end

    // bus and model checks sampled mid-cycle
    always @(negedge clk) begin
        if (rst) begin
            compare_value("o_psel", psel, 0);
            compare_value("o_instr_done", instr_done, 0);
            compare_value("o_error", error, 0);
            compare_value("o_reg_p", reg_p, 0);
            compare_value("o_reg_st", reg_st, 0);
            compare_value("o_reg_c", reg_c, 0);
        end else begin
            if (regs_pending) begin
                compare_value("o_reg_p", reg_p, m_p);
                compare_value("o_reg_st", reg_st, m_st);
                compare_value("o_reg_c", reg_c, m_c);
                regs_pending = 1'b0;
            end
            expect_true(!penable || psel, "penable high without psel");
            if (prev_setup) begin
                expect_true(psel && penable, "setup cycle not followed by access");
            end
            if (prev_wait) begin
                expect_true(psel && penable, "access ended before pready");
            end
            if (psel && !penable) begin
                setup_addr = paddr;
            end
            if (penable) begin
                compare_value("o_paddr", paddr, setup_addr);
            end
            if (psel && penable && pready) begin
                compare_value("o_paddr", paddr, exp_addr);
                exp_addr = exp_addr + 1;
            end
            prev_setup = psel && !penable;
            prev_wait = psel && penable && !pready;
            if (instr_done) begin
                expect_true(!error, "instruction completed after the error");
                compare_value("o_instr_pc", instr_pc, m_pc);
                done_count++;
                model_step();
                exp_addr = m_pc;
                regs_pending = 1'b1;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the program did not reach its end in time");
        $display("Something failed");
        $finish;
    end

    initial begin
        int mark;
        prdata = 4'h0;
        pready = 1'b0;
        build_program();

        mark = errors;
        @(negedge rst);
        @(negedge clk);
        compare_value("o_psel", psel, 0);
        compare_value("o_instr_done", instr_done, 0);
        compare_value("o_error", error, 0);
        compare_value("o_reg_p", reg_p, 0);
        compare_value("o_reg_st", reg_st, 0);
        compare_value("o_reg_c", reg_c, 0);
        @(posedge psel);
        #1;
        compare_value("o_paddr", paddr, RESET_PC);
        $display("test reset_state finished, %0d errors", errors - mark);

        mark = errors;
        while (!error) begin
            @(negedge clk);
        end
        compare_value("done_count", done_count, N_INSTR);
        // exactly the terminating nibble is read after the last instruction
        compare_value("exp_addr", exp_addr, term_addr + 1);
        $display("test program_run finished, %0d errors", errors - mark);

        mark = errors;
        repeat (50) begin
            @(negedge clk);
            expect_true(!psel, "new APB transfer started after the error");
            expect_true(!instr_done, "done pulse after the error");
            expect_true(error, "error flag dropped");
        end
        compare_value("done_count", done_count, N_INSTR);
        $display("test invalid_opcode finished, %0d errors", errors - mark);

        $display("checks done, %0d instructions, %0d errors", done_count, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* saturn_core.f */
source/saturn_pkg.sv
source/saturn_phase_gen.sv
source/saturn_fetch.sv
source/saturn_inst_decoder.sv
source/saturn_regs.sv
source/saturn_core.sv
bench/saturn_clock_gen.sv
bench/saturn_core_tb.sv

/* Makefile */
# Verilator build for the saturn core testbench

VERILATOR ?= verilator
FLIST     ?= saturn_core.f
TB_TOP    ?= saturn_core_tb
RTL_TOP   ?= saturn_core
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

$(OBJ_DIR)/V$(TB_TOP): $(shell cat $(FLIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TB_TOP)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf $(OBJ_DIR)
